// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen            = 32;
    localparam int reg_addr_width  = 5;
    localparam int imem_depth      = 64;
    localparam int imem_addr_width = 6;
    localparam int apb_addr_width  = 12;

    // major opcodes of the supported instructions
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_system = 7'b1110011;

    typedef enum logic [2:0] {
        cmd_nop,
        cmd_add,
        cmd_sub,
        cmd_lui,
        cmd_halt
    } exu_cmd_t;

    typedef enum logic [1:0] {
        imm_none,
        imm_i,
        imm_u
    } imm_kind_t;

    // apb map, imem sits at 0x000..0x0fc
    localparam logic [apb_addr_width-1:0] addr_imem_last = 12'h0FC;
    localparam logic [apb_addr_width-1:0] addr_ctrl      = 12'h100;
    localparam logic [apb_addr_width-1:0] addr_status    = 12'h104;
    localparam logic [apb_addr_width-1:0] addr_pc        = 12'h108;
    localparam logic [apb_addr_width-1:0] addr_retired   = 12'h10C;
    localparam logic [apb_addr_width-1:0] addr_regs_base = 12'h180;

endpackage

`default_nettype wire

// File: logic/dec_exe_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dec_exe_if import core_pkg::*; ();

    exu_cmd_t                  cmd;
    logic [xlen-1:0]           src1;
    logic [xlen-1:0]           src2;
    logic [xlen-1:0]           imm;
    logic                      use_imm;
    // zero when nothing is written back
    logic [reg_addr_width-1:0] rd;

    modport decoder  (output cmd, output src1, output src2, output imm, output use_imm, output rd);
    modport executor (input  cmd, input  src1, input  src2, input  imm, input  use_imm, input  rd);

endinterface

`default_nettype wire

// File: logic/inst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module inst_mem import core_pkg::*; (
    input  logic                       clk,
    input  logic                       we,
    input  logic [imem_addr_width-1:0] waddr,
    input  logic [xlen-1:0]            wdata,
    input  logic [imem_addr_width-1:0] raddr,
    output logic [xlen-1:0]            rdata
);

    logic [xlen-1:0] mem [imem_depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // fetch is combinational off the pc
    assign rdata = mem[raddr];

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import core_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [reg_addr_width-1:0] raddr1,
    input  logic [reg_addr_width-1:0] raddr2,
    input  logic [reg_addr_width-1:0] dbg_addr,
    output logic [xlen-1:0]           rdata1,
    output logic [xlen-1:0]           rdata2,
    output logic [xlen-1:0]           dbg_data,
    input  logic                      we,
    input  logic [reg_addr_width-1:0] waddr,
    input  logic [xlen-1:0]           wdata
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    function automatic logic [xlen-1:0] read_reg(input logic [reg_addr_width-1:0] addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1   = read_reg(raddr1);
    assign rdata2   = read_reg(raddr2);
    assign dbg_data = read_reg(dbg_addr);

endmodule

`default_nettype wire

// File: logic/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit import core_pkg::*; (
    input  logic [xlen-1:0]           inst,
    input  logic [xlen-1:0]           rdata1,
    input  logic [xlen-1:0]           rdata2,
    output logic [reg_addr_width-1:0] rs1_addr,
    output logic [reg_addr_width-1:0] rs2_addr,
    dec_exe_if.decoder                dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_kind_t  imm_kind;
    logic       src1_en;
    logic       src2_en;
    logic       write_en;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // disabled fields read back as zero
    assign rs1_addr = src1_en ? inst[19:15] : '0;
    assign rs2_addr = src2_en ? inst[24:20] : '0;
    assign dec.src1 = src1_en ? rdata1 : '0;
    assign dec.src2 = src2_en ? rdata2 : '0;
    assign dec.rd   = write_en ? inst[11:7] : '0;

    assign dec.use_imm = (imm_kind == imm_i);

    always_comb begin
        case (imm_kind)
            imm_i:   dec.imm = {{20{inst[31]}}, inst[31:20]};
            imm_u:   dec.imm = {inst[31:12], 12'b0};
            default: dec.imm = '0;
        endcase
    end

    always_comb begin
        dec.cmd  = cmd_nop;
        imm_kind = imm_none;
        src1_en  = 1'b0;
        src2_en  = 1'b0;
        write_en = 1'b0;
        casez ({funct7, funct3, opcode})
            {7'b???????, 3'b000, op_imm}: begin
                // addi
                dec.cmd  = cmd_add;
                imm_kind = imm_i;
                src1_en  = 1'b1;
                write_en = 1'b1;
            end
            {7'b0000000, 3'b000, op_reg}: begin
                dec.cmd  = cmd_add;
                src1_en  = 1'b1;
                src2_en  = 1'b1;
                write_en = 1'b1;
            end
            {7'b0100000, 3'b000, op_reg}: begin
                dec.cmd  = cmd_sub;
                src1_en  = 1'b1;
                src2_en  = 1'b1;
                write_en = 1'b1;
            end
            {7'b???????, 3'b???, op_lui}: begin
                dec.cmd  = cmd_lui;
                imm_kind = imm_u;
                write_en = 1'b1;
            end
            {7'b0000000, 3'b000, op_system}: begin
                // ebreak only, ecall falls through as a nop
                if (inst[24:7] == 18'h02000) begin
                    dec.cmd = cmd_halt;
                end
            end
            default: begin
                dec.cmd = cmd_nop;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit import core_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      run,
    input  logic                      start,
    dec_exe_if.executor               dec,
    output logic                      we,
    output logic [reg_addr_width-1:0] waddr,
    output logic [xlen-1:0]           wdata,
    output logic [xlen-1:0]           pc,
    output logic                      halt_now
);

    logic            commit;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] result;

    // the start cycle only reloads the pc
    assign commit = run && !start;

    assign op_b = dec.use_imm ? dec.imm : dec.src2;

    always_comb begin
        case (dec.cmd)
            cmd_add: result = dec.src1 + op_b;
            cmd_sub: result = dec.src1 - op_b;
            cmd_lui: result = dec.imm;
            default: result = '0;
        endcase
    end

    // rd is already zero for anything that does not write
    assign we       = commit && (dec.rd != '0);
    assign waddr    = dec.rd;
    assign wdata    = result;
    assign halt_now = commit && (dec.cmd == cmd_halt);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (start) begin
            pc <= '0;
        end else if (commit && dec.cmd != cmd_halt) begin
            pc <= pc + 32'd4;
        end
    end

endmodule

`default_nettype wire

// File: logic/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs import core_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [apb_addr_width-1:0]  paddr,
    input  logic [xlen-1:0]            pwdata,
    output logic [xlen-1:0]            prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       inst_mem_we,
    output logic [imem_addr_width-1:0] inst_mem_waddr,
    output logic [xlen-1:0]            inst_mem_wdata,
    output logic [reg_addr_width-1:0]  dbg_addr,
    input  logic [xlen-1:0]            dbg_data,
    input  logic [xlen-1:0]            pc,
    input  logic                       halt_now,
    output logic                       run,
    output logic                       start
);

    logic            access;
    logic            wr;
    logic            in_imem;
    logic            in_ctrl;
    logic            in_status;
    logic            in_pc;
    logic            in_retired;
    logic            in_regs;
    logic            start_req;
    logic            halted;
    logic [xlen-1:0] retired;

    assign access = psel && penable;
    assign wr     = access && pwrite;

    // word granular decode, byte offset bits are ignored
    assign in_imem    = (paddr <= addr_imem_last);
    assign in_ctrl    = (paddr[11:2] == addr_ctrl[11:2]);
    assign in_status  = (paddr[11:2] == addr_status[11:2]);
    assign in_pc      = (paddr[11:2] == addr_pc[11:2]);
    assign in_retired = (paddr[11:2] == addr_retired[11:2]);
    assign in_regs    = (paddr[11:7] == addr_regs_base[11:7]);

    assign pready  = 1'b1;
    assign pslverr = access &&
                     !(in_imem || in_ctrl || in_status || in_pc || in_retired || in_regs);

    assign inst_mem_we    = wr && in_imem;
    assign inst_mem_waddr = paddr[imem_addr_width+1:2];
    assign inst_mem_wdata = pwdata;

    assign dbg_addr = paddr[reg_addr_width+1:2];

    // a start while running is dropped
    assign start_req = wr && in_ctrl && pwdata[0] && !run;

    always_ff @(posedge clk) begin
        if (rst) begin
            run     <= 1'b0;
            start   <= 1'b0;
            halted  <= 1'b0;
            retired <= '0;
        end else begin
            start <= start_req;
            if (start_req) begin
                run     <= 1'b1;
                halted  <= 1'b0;
                retired <= '0;
            end else if (run && !start) begin
                retired <= retired + 1'b1;
                if (halt_now) begin
                    run    <= 1'b0;
                    halted <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        if (in_status) begin
            prdata = {30'b0, halted, run};
        end else if (in_pc) begin
            prdata = pc;
        end else if (in_retired) begin
            prdata = retired;
        end else if (in_regs) begin
            prdata = dbg_data;
        end else begin
            prdata = '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import core_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [apb_addr_width-1:0] paddr,
    input  logic [xlen-1:0]           pwdata,
    output logic [xlen-1:0]           prdata,
    output logic                      pready,
    output logic                      pslverr
);

    logic                       inst_mem_we;
    logic [imem_addr_width-1:0] inst_mem_waddr;
    logic [xlen-1:0]            inst_mem_wdata;
    logic [xlen-1:0]            inst;
    logic [reg_addr_width-1:0]  rs1_addr;
    logic [reg_addr_width-1:0]  rs2_addr;
    logic [xlen-1:0]            rdata1;
    logic [xlen-1:0]            rdata2;
    logic [reg_addr_width-1:0]  dbg_addr;
    logic [xlen-1:0]            dbg_data;
    logic                       rf_we;
    logic [reg_addr_width-1:0]  rf_waddr;
    logic [xlen-1:0]            rf_wdata;
    logic [xlen-1:0]            pc;
    logic                       halt_now;
    logic                       run;
    logic                       start;

    dec_exe_if u_dec_exe_if ();

    inst_mem u_inst_mem (
        .clk   (clk),
        .we    (inst_mem_we),
        .waddr (inst_mem_waddr),
        .wdata (inst_mem_wdata),
        .raddr (pc[imem_addr_width+1:2]),
        .rdata (inst)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .raddr1   (rs1_addr),
        .raddr2   (rs2_addr),
        .dbg_addr (dbg_addr),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .dbg_data (dbg_data),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata)
    );

    decode_unit u_decode_unit (
        .inst     (inst),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .dec      (u_dec_exe_if.decoder)
    );

    execute_unit u_execute_unit (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .start    (start),
        .dec      (u_dec_exe_if.executor),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata),
        .pc       (pc),
        .halt_now (halt_now)
    );

    ctrl_regs u_ctrl_regs (
        .clk            (clk),
        .rst            (rst),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .inst_mem_we    (inst_mem_we),
        .inst_mem_waddr (inst_mem_waddr),
        .inst_mem_wdata (inst_mem_wdata),
        .dbg_addr       (dbg_addr),
        .dbg_data       (dbg_data),
        .pc             (pc),
        .halt_now       (halt_now),
        .run            (run),
        .start          (start)
    );

endmodule

`default_nettype wire

// File: verif/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import core_pkg::*; ();

    localparam int max_cycles = 5000;
    // ebreak encoding
    localparam logic [31:0] halt_word = 32'h00100073;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] model [32];
    logic [31:0] prog [$];
    int          cycle_count = 0;

    cpu_core u_cpu_core (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("TESTS FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic fail_now(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    assert property (@(posedge clk) disable iff (rst) (psel && penable) |-> pready)
        else fail_now("pready low during an APB access");
    assert property (@(posedge clk) disable iff (rst) !(psel && penable) |-> !pslverr)
        else fail_now("pslverr high outside an APB access");

    function automatic void put_addi(input int rd, input int rs1, input logic [11:0] imm);
        prog.push_back({imm, 5'(rs1), 3'b000, 5'(rd), 7'b0010011});
        if (rd != 0) model[rd] = model[rs1] + {{20{imm[11]}}, imm};
    endfunction

    function automatic void put_arith(input logic sub, input int rd, input int rs1, input int rs2);
        prog.push_back({1'b0, sub, 5'b0, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011});
        if (rd != 0) model[rd] = sub ? model[rs1] - model[rs2] : model[rs1] + model[rs2];
    endfunction

    function automatic void put_lui(input int rd, input logic [19:0] imm);
        prog.push_back({imm, 5'(rd), 7'b0110111});
        if (rd != 0) model[rd] = {imm, 12'b0};
    endfunction

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                            input logic exp_err, output logic [31:0] rdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #10;
        rdata = prdata;
        assert (pready) else fail_now("pready low in the access phase");
        assert (pslverr == exp_err)
            else fail_now($sformatf("pslverr %0b at 0x%03h, expected %0b", pslverr, addr, exp_err));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err = 1'b0);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic check_read(input logic [11:0] addr, input logic [31:0] exp, input string what);
        logic [31:0] got;
        apb_xfer(1'b0, addr, '0, 1'b0, got);
        assert (got === exp)
            else fail_now($sformatf("%s read 0x%08h, expected 0x%08h", what, got, exp));
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            apb_write(12'(i * 4), prog[i]);
        end
    endtask

    // start, poll for halted, then check status, pc and retired count
    task automatic run_to_halt();
        logic [31:0] status;
        int          n;
        n = prog.size();
        apb_write(addr_ctrl, 32'h1);
        status = '0;
        while (!status[1]) begin
            apb_xfer(1'b0, addr_status, '0, 1'b0, status);
        end
        check_read(addr_status, 32'h2, "status after halt");
        check_read(addr_pc, 32'((n - 1) * 4), "pc after halt");
        check_read(addr_retired, 32'(n), "retired count");
    endtask

    task automatic check_regs();
        for (int r = 0; r < 32; r++) begin
            check_read(addr_regs_base + 12'(r * 4), model[r], $sformatf("x%0d", r));
        end
    endtask

    initial begin
        logic [31:0] scratch;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(32'hfdf969b6));
        foreach (model[i]) model[i] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_read(addr_status, 32'h0, "status after reset");
        check_read(addr_pc, 32'h0, "pc after reset");
        check_read(addr_retired, 32'h0, "retired after reset");

        // every source register is written earlier in the program, so a rerun is idempotent
        put_lui(1, 20'h12345);
        put_addi(2, 0, 12'd100);
        put_addi(3, 0, 12'hff9);
        put_arith(1'b0, 4, 2, 3);
        put_arith(1'b1, 5, 2, 3);
        put_addi(6, 1, 12'h678);
        put_arith(1'b1, 7, 3, 6);
        put_addi(0, 2, 12'd5);
        // lw x8 and ecall retire as no-ops
        prog.push_back(32'h00002403);
        prog.push_back(32'h00000073);
        put_arith(1'b0, 9, 4, 0);
        put_lui(31, 20'hfffff);
        put_arith(1'b0, 30, 31, 6);
        prog.push_back(halt_word);
        load_program();
        run_to_halt();
        check_regs();

        // unmapped accesses and ignored writes
        apb_xfer(1'b0, 12'h110, '0, 1'b1, scratch);
        apb_xfer(1'b0, 12'h200, '0, 1'b1, scratch);
        apb_write(12'h17C, 32'hdeadbeef, 1'b1);
        apb_write(12'hFFC, 32'hdeadbeef, 1'b1);
        apb_write(addr_pc, 32'h40);
        apb_write(addr_retired, 32'h99);
        check_read(addr_pc, 32'((prog.size() - 1) * 4), "pc after write");
        check_read(addr_retired, 32'(prog.size()), "retired after write");
        check_read(12'h000, 32'h0, "imem readback");
        run_to_halt();
        check_regs();

        prog.delete();
        repeat (40) begin
            if ($urandom_range(1, 0) == 0) begin
                put_addi($urandom_range(31, 0), $urandom_range(31, 0), 12'($urandom()));
            end else begin
                put_arith(1'b0, $urandom_range(31, 0), $urandom_range(31, 0),
                          $urandom_range(31, 0));
            end
        end
        prog.push_back(halt_word);
        load_program();
        run_to_halt();
        check_regs();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
logic/core_pkg.sv
logic/dec_exe_if.sv
logic/inst_mem.sv
logic/reg_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/ctrl_regs.sv
logic/cpu_core.sv
verif/cpu_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f project.f -o cpu_tb_sim

./obj_dir/cpu_tb_sim 2>&1 | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
